/* ov5640_cfg_pkg.sv */
`default_nettype none

package ov5640_cfg_pkg;

  // Sensor start-up table size
  localparam int CFG_TABLE_DEPTH = 24;                        // Register writes in the table
  localparam int CFG_INDEX_W     = $clog2(CFG_TABLE_DEPTH + 1); // Index can also hold the depth

  // Power-up wait before the first SCCB write
  localparam int CFG_WAIT_CYCLES = 30000;                     // Sensor supply and XCLK settle time
  localparam int CFG_WAIT_W      = $clog2(CFG_WAIT_CYCLES + 1); // Counter reaches the full count

  // Last counter value before the wait is over
  localparam logic [CFG_WAIT_W-1:0] CFG_WAIT_LAST = CFG_WAIT_W'(CFG_WAIT_CYCLES - 1);

  // Table position
  typedef logic [CFG_INDEX_W-1:0] cfg_index_t;

  // Index value one past the last entry, reached after the final write
  localparam cfg_index_t CFG_INDEX_END = cfg_index_t'(CFG_TABLE_DEPTH);

  // One sensor register write as stored in the table
  // The table keeps the raw word, the SCCB engine splits it into address and value
  typedef union packed {
    logic [23:0] raw;               // Whole word, {addr, val}
    struct packed {
      logic [15:0] reg_addr;        // OV5640 register address
      logic [7:0]  reg_val;         // Byte written to it
    } fields;
  } cfg_word_u;

  // Request bundle towards the write engine
  typedef struct packed {
    logic      start;               // One-cycle write trigger
    cfg_word_u word;                // Held until the engine reports the end
  } cfg_req_t;

endpackage

`default_nettype wire

/* power_up_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module power_up_timer (
  input  logic sys_clk,             // System clock
  input  logic sys_rst_n,           // Async reset, active low
  output logic wait_done            // High once the power-up wait has elapsed
);

  logic [ov5640_cfg_pkg::CFG_WAIT_W-1:0] wait_cnt;  // Cycles since reset release

  // Counter stops once the wait is flagged, so it rests at CFG_WAIT_CYCLES
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wait_cnt <= '0;
    end else if (!wait_done) begin
      wait_cnt <= wait_cnt + 1'b1;  // Counts the cycle just ending
    end
  end

  // Registered flag, set at the edge that counts the last wait cycle
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wait_done <= 1'b0;
    end else if (wait_cnt == ov5640_cfg_pkg::CFG_WAIT_LAST) begin
      wait_done <= 1'b1;            // Sticky until reset
    end
  end

endmodule

`default_nettype wire

/* cfg_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module cfg_sequencer (
  input  logic                      sys_clk,    // System clock
  input  logic                      sys_rst_n,  // Async reset, active low
  input  logic                      wait_done,  // Power-up wait over
  input  logic                      cfg_end,    // Write engine finished the current write
  input  ov5640_cfg_pkg::cfg_word_u  rom_word,   // Table entry at rom_index
  output ov5640_cfg_pkg::cfg_index_t rom_index,  // Entry being written
  output ov5640_cfg_pkg::cfg_req_t   cfg_req,    // Start pulse and word to the engine
  output logic                      cfg_done    // Whole table written
);

  // Sequencer states
  // WAIT_POWER  sensor still settling
  // ISSUE       start pulse cycle
  // AWAIT_END   engine busy, word held
  // DONE        table exhausted
  enum logic [1:0] {
    WAIT_POWER,
    ISSUE,
    AWAIT_END,
    DONE
  } state;

  ov5640_cfg_pkg::cfg_index_t next_index;      // Position after the current write

  assign next_index = rom_index + 1'b1;

  // State and index
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state     <= WAIT_POWER;
      rom_index <= '0;                         // First write is entry 0
    end else begin
      case (state)
        WAIT_POWER: begin
          if (wait_done) begin
            state <= ISSUE;                    // Start shows in the next cycle
          end
        end
        ISSUE: begin
          state <= AWAIT_END;                  // Engine needs at least one cycle
        end
        AWAIT_END: begin
          if (cfg_end) begin
            rom_index <= next_index;           // New word visible with the next start
            if (next_index == ov5640_cfg_pkg::CFG_INDEX_END) begin
              state <= DONE;                   // That was the last entry
            end else begin
              state <= ISSUE;
            end
          end
        end
        DONE: begin
          state <= DONE;                       // Only reset leaves here, late ends ignored
        end
        default: begin
          state <= WAIT_POWER;
        end
      endcase
    end
  end

  // Outputs decoded from the state register
  always_comb begin
    cfg_req.start = (state == ISSUE);          // Exactly one cycle per entry
    cfg_req.word  = rom_word;                  // Stable while index holds
    if (state == DONE) begin
      cfg_req.word.raw = '0;                   // Zeroed data after completion
    end
  end

  assign cfg_done = (state == DONE);

endmodule

`default_nettype wire

/* ov5640_reg_table.sv */
`timescale 1ns/1ns
`default_nettype none

module ov5640_reg_table (
  input  ov5640_cfg_pkg::cfg_index_t rom_index,  // Table position
  output ov5640_cfg_pkg::cfg_word_u  rom_word    // {reg_addr, reg_val} at that position
);

  // Start-up writes, in sensor bring-up order
  always_comb begin
    case (rom_index)
      // Clock source and software reset
      0: begin
        rom_word.raw = 24'h310311;   // System clock from pad, PLL bypass
      end
      1: begin
        rom_word.raw = 24'h300882;   // Software reset, power down
      end
      2: begin
        rom_word.raw = 24'h300802;   // Release reset
      end
      3: begin
        rom_word.raw = 24'h310303;   // System clock from PLL
      end
      // DVP pin directions
      4: begin
        rom_word.raw = 24'h3017ff;   // D[9:6] and sync pins as outputs
      end
      5: begin
        rom_word.raw = 24'h3018ff;   // D[5:0] as outputs
      end
      // PLL setup
      6: begin
        rom_word.raw = 24'h30341a;   // Charge pump, bit divider 2.5
      end
      7: begin
        rom_word.raw = 24'h303521;   // System divider, MIPI divider
      end
      8: begin
        rom_word.raw = 24'h3036a0;   // PLL multiplier
      end
      9: begin
        rom_word.raw = 24'h303712;   // Root divider, pre-divider
      end
      10: begin
        rom_word.raw = 24'h310801;   // PCLK and SCLK dividers
      end
      // Undocumented analog settings
      11: begin
        rom_word.raw = 24'h363036;
      end
      12: begin
        rom_word.raw = 24'h36310e;
      end
      13: begin
        rom_word.raw = 24'h3632e2;
      end
      14: begin
        rom_word.raw = 24'h363312;
      end
      15: begin
        rom_word.raw = 24'h3621e0;
      end
      16: begin
        rom_word.raw = 24'h3704a0;
      end
      17: begin
        rom_word.raw = 24'h37035a;
      end
      18: begin
        rom_word.raw = 24'h371578;
      end
      19: begin
        rom_word.raw = 24'h371701;
      end
      20: begin
        rom_word.raw = 24'h370b60;
      end
      21: begin
        rom_word.raw = 24'h37051a;
      end
      22: begin
        rom_word.raw = 24'h390502;
      end
      23: begin
        rom_word.raw = 24'h390610;   // Last entry
      end
      default: begin
        rom_word.raw = 24'h000000;   // Past the table
      end
    endcase
  end

endmodule

`default_nettype wire

/* ov5640_cfg_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ov5640_cfg_top (
  input  logic                    sys_clk,     // System clock
  input  logic                    sys_rst_n,   // Async reset, active low
  input  logic                    cfg_end,     // Write engine done with one write
  output ov5640_cfg_pkg::cfg_req_t cfg_req,     // Write request to the engine
  output logic                    cfg_done     // All sensor registers written
);

  logic                       wait_done;       // Sensor power-up wait over
  ov5640_cfg_pkg::cfg_index_t rom_index;       // Current table position
  ov5640_cfg_pkg::cfg_word_u  rom_word;        // Entry at that position

  // Power-up delay before any SCCB traffic
  power_up_timer u_power_up_timer (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .wait_done (wait_done)
  );

  // One write outstanding at a time
  cfg_sequencer u_cfg_sequencer (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .wait_done (wait_done),
    .cfg_end   (cfg_end),
    .rom_word  (rom_word),
    .rom_index (rom_index),
    .cfg_req   (cfg_req),
    .cfg_done  (cfg_done)
  );

  // Combinational lookup, same cycle as the index
  ov5640_reg_table u_ov5640_reg_table (
    .rom_index (rom_index),
    .rom_word  (rom_word)
  );

endmodule

`default_nettype wire

/* tb_ov5640_cfg_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ov5640_cfg_assert (
  input logic                     sys_clk,    // DUT clock
  input logic                     sys_rst_n,  // DUT reset
  input logic                     cfg_end,    // Engine end pulse
  input ov5640_cfg_pkg::cfg_req_t cfg_req,    // Request bundle
  input logic                     cfg_done    // Sequence finished
);

  start_single_cycle: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n) cfg_req.start |=> !cfg_req.start
  ) else $error("start high for two cycles");

  no_start_after_done: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n) !(cfg_req.start && cfg_done)
  ) else $error("start issued after done");

  // Word only moves with a new start or with completion
  word_held: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
      (!cfg_req.start && !cfg_done) |-> $stable(cfg_req.word)
  ) else $error("request word changed while a write was outstanding");

  done_after_end: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n) $rose(cfg_done) |-> $past(cfg_end)
  ) else $error("done rose without an end pulse");

  done_sticky: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n) cfg_done |=> cfg_done
  ) else $error("done fell without reset");

endmodule

bind ov5640_cfg_top tb_ov5640_cfg_assert u_cfg_assert (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .cfg_end   (cfg_end),
  .cfg_req   (cfg_req),
  .cfg_done  (cfg_done)
);

`default_nettype wire

/* tb_ov5640_cfg.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ov5640_cfg;

  localparam int WAIT  = ov5640_cfg_pkg::CFG_WAIT_CYCLES;  // Power-up wait in cycles
  localparam int DEPTH = ov5640_cfg_pkg::CFG_TABLE_DEPTH;  // Writes per sequence
  // Two power-up waits with reset, every write at its slowest, margin
  localparam int TIMEOUT_CYCLES = 2 * (WAIT + 10) + DEPTH * 25 + 200;

  logic                     sys_clk;       // 100 ns clock
  logic                     sys_rst_n;     // Active low reset
  logic                     cfg_end;       // Engine model end pulse
  ov5640_cfg_pkg::cfg_req_t cfg_req;       // Request seen by the engine
  logic                     cfg_done;      // Sequence finished

  int          release_edges;              // Rising edges counted by the DUT since release
  logic [23:0] ref_table [0:ov5640_cfg_pkg::CFG_TABLE_DEPTH-1];  // Expected {addr, val}

  ov5640_cfg_top UUT (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .cfg_end   (cfg_end),
    .cfg_req   (cfg_req),
    .cfg_done  (cfg_done)
  );

  initial begin
    sys_clk = 1'b0;
    forever begin
      #50 sys_clk = ~sys_clk;              // 100 ns period
    end
  end

  // Edge 0 is the one that releases reset, the timer counts from edge 1
  always @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      release_edges <= 0;
    end else begin
      release_edges <= release_edges + 1;
    end
  end

  // OV5640 start-up writes, clock source first
  initial begin
    ref_table = '{
      24'h310311, 24'h300882, 24'h300802, 24'h310303,
      24'h3017ff, 24'h3018ff, 24'h30341a, 24'h303521,
      24'h3036a0, 24'h303712, 24'h310801, 24'h363036,
      24'h36310e, 24'h3632e2, 24'h363312, 24'h3621e0,
      24'h3704a0, 24'h37035a, 24'h371578, 24'h371701,
      24'h370b60, 24'h37051a, 24'h390502, 24'h390610
    };
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "Run stopped after a failure");
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("FAIL %s: expected 0x%0h, actual 0x%0h",
                                  test_name, expected, actual));
    end
  endtask

  // No request and no done in the current cycle
  task automatic expect_idle(input string test_name);
    check_value(test_name, 32'h0, 32'(cfg_req.start));
    check_value(test_name, 32'h0, 32'(cfg_done));
  endtask

  // Four cycles of reset, released at a rising edge
  task automatic apply_reset(input string test_name);
    @(posedge sys_clk);
    sys_rst_n <= 1'b0;
    cfg_end   <= 1'b0;
    repeat (4) begin
      @(negedge sys_clk);
      expect_idle(test_name);
      check_value(test_name, 32'(ref_table[0]), 32'(cfg_req.word.raw));  // Index back at 0
      @(posedge sys_clk);
    end
    sys_rst_n <= 1'b1;
  endtask

  task automatic reset_quiet();
    apply_reset("reset_quiet");
    while (release_edges < WAIT / 2) begin
      @(negedge sys_clk);
      expect_idle("reset_quiet");
      check_value("reset_quiet", 32'(ref_table[0]), 32'(cfg_req.word.raw));
    end
  endtask

  // End pulse in the middle of the power-up wait
  task automatic ignored_early_end();
    @(posedge sys_clk);
    cfg_end <= 1'b1;                       // No write outstanding
    @(negedge sys_clk);
    expect_idle("ignored_early_end");
    @(posedge sys_clk);
    cfg_end <= 1'b0;
    @(negedge sys_clk);
    expect_idle("ignored_early_end");
    check_value("ignored_early_end", 32'(ref_table[0]), 32'(cfg_req.word.raw));
  endtask

  // wait_done is set at edge WAIT and sampled at edge WAIT+1
  task automatic first_write_timing(input string test_name);
    @(negedge sys_clk);
    while (release_edges < WAIT + 1) begin
      expect_idle(test_name);
      @(negedge sys_clk);
    end
    check_value(test_name, 32'h1, 32'(cfg_req.start));
    check_value(test_name, 32'(ref_table[0]), 32'(cfg_req.word.raw));
    check_value(test_name, 32'h3103, 32'(cfg_req.word.fields.reg_addr));  // Clock source reg
    check_value(test_name, 32'h11, 32'(cfg_req.word.fields.reg_val));
  endtask

  // Write-engine model, entered at the middle of a start cycle
  task automatic serve_write(input string test_name, input int index);
    ov5640_cfg_pkg::cfg_word_u word_seen;
    logic [15:0]               addr_seen;
    logic [7:0]                val_seen;
    int                        delay;
    word_seen = cfg_req.word;              // Engine latches the word with start
    addr_seen = word_seen.fields.reg_addr; // Sent as two SCCB bytes
    val_seen  = word_seen.fields.reg_val;
    check_value(test_name, 32'h1, 32'(cfg_req.start));
    check_value(test_name, 32'(ref_table[index]), 32'(word_seen.raw));
    check_value(test_name, 32'(ref_table[index][23:8]), 32'(addr_seen));
    check_value(test_name, 32'(ref_table[index][7:0]), 32'(val_seen));
    delay = $urandom_range(20, 1);         // Bus time of the write
    repeat (delay) begin
      @(negedge sys_clk);
      expect_idle(test_name);
      check_value(test_name, 32'(ref_table[index]), 32'(cfg_req.word.raw));  // Held while busy
    end
    @(posedge sys_clk);
    cfg_end <= 1'b1;
    @(negedge sys_clk);
    expect_idle(test_name);
    check_value(test_name, 32'(ref_table[index]), 32'(cfg_req.word.raw));  // Held to the end
    @(posedge sys_clk);
    cfg_end <= 1'b0;                       // DUT samples the pulse at this edge
    @(negedge sys_clk);
  endtask

  task automatic full_sequence();
    for (int i = 0; i < DEPTH; i++) begin
      serve_write("full_sequence", i);
      if (i < DEPTH - 1) begin
        check_value("full_sequence", 32'h1, 32'(cfg_req.start));  // One cycle after the end
        check_value("full_sequence", 32'h0, 32'(cfg_done));
      end
    end
  endtask

  task automatic completion();
    check_value("completion", 32'h1, 32'(cfg_done));       // Rose with the last end
    check_value("completion", 32'h0, 32'(cfg_req.start));
    check_value("completion", 32'h0, 32'(cfg_req.word.raw));
    repeat (3) begin
      @(posedge sys_clk);
      cfg_end <= 1'b1;                     // Stray end after completion
      @(posedge sys_clk);
      cfg_end <= 1'b0;
      repeat (3) begin
        @(negedge sys_clk);
        check_value("completion", 32'h0, 32'(cfg_req.start));
        check_value("completion", 32'h1, 32'(cfg_done));
        check_value("completion", 32'h0, 32'(cfg_req.word.raw));
      end
    end
    apply_reset("completion");             // Done cleared during reset
    first_write_timing("completion");
  endtask

  initial begin
    void'($urandom(50));                   // Engine delays repeat run to run
    sys_rst_n <= 1'b0;
    cfg_end   <= 1'b0;
    reset_quiet();
    ignored_early_end();
    first_write_timing("first_write_timing");
    full_sequence();
    completion();
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) begin
      @(posedge sys_clk);
    end
    stop_with_failure("Timeout: the configuration sequence did not finish in time");
  end

endmodule

`default_nettype wire

/* project.f */
ov5640_cfg_pkg.sv
power_up_timer.sv
cfg_sequencer.sv
ov5640_reg_table.sv
ov5640_cfg_top.sv
tb_ov5640_cfg_assert.sv
tb_ov5640_cfg.sv

/* Makefile */
SIM := obj_dir/Vtb_ov5640_cfg

.PHONY: all run clean

all: $(SIM)

$(SIM): project.f ov5640_cfg_pkg.sv power_up_timer.sv cfg_sequencer.sv \
        ov5640_reg_table.sv ov5640_cfg_top.sv tb_ov5640_cfg_assert.sv tb_ov5640_cfg.sv
	verilator --binary --timing --assert --top-module tb_ov5640_cfg -f project.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
